/* Bender.yml */
package:
  name: obj_linebuf

sources:
  - files:
      - hdl/obj_pkg.sv
      - hdl/obj_ram.sv
      - hdl/obj_table.sv
      - hdl/obj_timing.sv
      - hdl/obj_scan_buf.sv
      - hdl/obj_line_reader.sv
      - hdl/obj_top.sv
  - target: test
    files:
      - verification/obj_tb_assert.sv
      - verification/obj_tb.sv

/* compile.f */
hdl/obj_pkg.sv
hdl/obj_ram.sv
hdl/obj_table.sv
hdl/obj_timing.sv
hdl/obj_scan_buf.sv
hdl/obj_line_reader.sv
hdl/obj_top.sv
verification/obj_tb_assert.sv
verification/obj_tb.sv

/* hdl/obj_line_reader.sv */
`default_nettype none

module obj_line_reader
    import obj_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        draw_cen,
    input  wire        hinit,
    input  wire        rom_wait,
    output slot_addr_t rd_slot,
    output logic       rd_step,
    input  obj_byte_t  buf_q,
    output obj_entry_t obj_entry,
    output logic       obj_valid
);

    rd_state_t                state;
    logic                     armed;      // a read-out is due on this line
    logic [$clog2(H_READ):0]  step_cnt;
    logic [2:0]               cap_d;
    logic                     cap;

    assign rd_step = (state == READ) && draw_cen && !rom_wait;
    assign cap     = cap_d[2];            // buf_q holds the byte now

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            armed     <= 1'b0;
            step_cnt  <= '0;
            cap_d     <= '0;
            obj_valid <= 1'b0;
            rd_slot   <= slot_addr_t'(SLOT_FIRST*4);
        end else begin
            cap_d     <= {cap_d[1:0], rd_step};
            obj_valid <= cap && (rd_slot[1:0] == 2'd3);
            // address holds until the clear write has landed
            if (cap) begin
                rd_slot <= rd_slot + 1'b1;
            end
            if (hinit) begin
                state    <= IDLE;
                armed    <= 1'b1;
                step_cnt <= 1;    // hinit is step 0
                rd_slot  <= slot_addr_t'(SLOT_FIRST*4);
            end else begin
                case (state)
                    IDLE: begin
                        if (draw_cen && armed) begin
                            if (step_cnt == ($bits(step_cnt))'(H_READ - 1)) begin
                                state <= READ;
                                armed <= 1'b0;
                            end else begin
                                step_cnt <= step_cnt + 1'b1;
                            end
                        end
                    end
                    READ: begin
                        if (rd_step && (rd_slot == '1)) begin
                            state <= DRAIN;
                        end
                    end
                    DRAIN: if (cap) state <= IDLE;   // last byte captured
                    default: state <= IDLE;
                endcase
            end
        end
    end

    // bytes enter at the top, byte 0 ends up in b0 after four captures
    always_ff @(posedge clk) begin
        if (cap) begin
            obj_entry <= '{b3: buf_q, b2: obj_entry.b3, b1: obj_entry.b2, b0: obj_entry.b1};
        end
    end

endmodule

`default_nettype wire

/* hdl/obj_pkg.sv */
`default_nettype none

package obj_pkg;

    // data widths
    typedef logic [7:0] obj_byte_t;   // object attribute or line buffer byte
    typedef logic [8:0] tab_addr_t;   // attribute table byte address
    typedef logic [6:0] slot_addr_t;  // line bank address, {slot, byte}
    typedef logic [7:0] vpos_t;       // line number

    // one table entry as delivered by the reader, b2 holds Y
    typedef struct packed {
        obj_byte_t b3;
        obj_byte_t b2;
        obj_byte_t b1;
        obj_byte_t b0;
    } obj_entry_t;

    // object table and line buffer
    localparam int        OBJ_COUNT    = 96;
    localparam int        OBJ_MAX_LINE = 24;
    localparam int        SLOT_FIRST   = 8;     // reader covers slots 8 to 31
    localparam obj_byte_t CLR_VAL      = 8'hF8; // empty byte, off screen Y

    // video timing
    localparam int CEN_DIV     = 4;   // draw_cen is one clock in four
    localparam int H_TOTAL     = 256;
    localparam int V_TOTAL     = 262;
    localparam int V_VIS_START = 16;
    localparam int V_VIS_END   = 239;
    localparam int H_READ      = 8;   // draw step where read-out begins

    typedef enum logic {
        SEARCH,
        TRANSFER
    } scan_state_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN
    } rd_state_t;

endpackage

`default_nettype wire

/* hdl/obj_ram.sv */
`default_nettype none

module obj_ram
    import obj_pkg::*;
(
    input  wire        clk,
    input  slot_addr_t addr,
    input  obj_byte_t  data,
    input  wire        we,
    output obj_byte_t  q
);

    obj_byte_t mem [2**$bits(slot_addr_t)];

    // power up empty, every byte holds the clear value
    initial begin
        for (int i = 0; i < 2**$bits(slot_addr_t); i++) begin
            mem[i] = CLR_VAL;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
            q         <= data;      // write-first
        end else begin
            q <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* hdl/obj_scan_buf.sv */
`default_nettype none

// per-line object search into a pair of ping-pong line banks
// one bank is filled for the next line while the other is read and cleared
module obj_scan_buf
    import obj_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        draw_cen,
    input  wire        hinit,
    input  wire        lvbl,
    input  wire        flip,
    input  vpos_t      v,
    output tab_addr_t  scan_addr,
    input  obj_byte_t  table_q,
    input  slot_addr_t rd_slot,
    input  wire        rd_step,
    output obj_byte_t  buf_q
);

    logic        bank_sel;       // low: search fills bank a, bank b is read
    vpos_t       vf;
    scan_state_t state;
    logic        fill;           // search is over for this line
    logic [4:0]  post_scan;      // match count within the line
    logic [7:0]  vsum;
    logic        match;
    logic        last_obj;
    logic [2:0]  step_d;         // rd_step delayed by one, two, three clocks
    logic        srch_we;
    logic        clr_we;
    slot_addr_t  srch_addr;

    slot_addr_t  addr_a, addr_b;
    obj_byte_t   data_a, data_b;
    logic        we_a, we_b;
    obj_byte_t   q_a, q_b;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bank_sel <= 1'b0;
        end else if (hinit) begin
            bank_sel <= ~bank_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (hinit) begin
            vf <= v ^ {8{flip}};
        end
    end

    // Y + ~vf + K, K is 254 normally and 2 when flipped
    assign vsum     = table_q + ~vf + {{6{~flip}}, 2'b10};
    assign match    = &vsum[7:4];   // 16 lines tall
    assign last_obj = (scan_addr[8:2] == 7'(OBJ_COUNT - 1));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state     <= SEARCH;
            fill      <= 1'b1;      // idle until the first line starts
            scan_addr <= tab_addr_t'(2);
            post_scan <= '0;
        end else if (draw_cen) begin
            if (hinit) begin
                state     <= SEARCH;
                fill      <= 1'b0;
                scan_addr <= tab_addr_t'(2);  // Y byte of entry 0
                post_scan <= '0;
            end else begin
                case (state)
                    SEARCH: begin
                        if (lvbl && !fill) begin
                            if (match) begin
                                scan_addr[1:0] <= 2'd0;
                                state          <= TRANSFER;
                            end else if (last_obj) begin
                                fill <= 1'b1;
                            end else begin
                                scan_addr <= scan_addr + tab_addr_t'(4);
                            end
                        end
                    end
                    TRANSFER: begin
                        if (scan_addr[1:0] == 2'd3) begin
                            state <= SEARCH;
                            if (post_scan == 5'(OBJ_MAX_LINE - 1) || last_obj) begin
                                fill <= 1'b1;
                            end else begin
                                post_scan <= post_scan + 1'b1;
                                scan_addr <= scan_addr + tab_addr_t'(3);  // next Y
                            end
                        end else begin
                            scan_addr[1:0] <= scan_addr[1:0] + 2'd1;
                        end
                    end
                    default: state <= SEARCH;
                endcase
            end
        end
    end

    // table_q matches scan_addr on every draw_cen
    assign srch_we   = draw_cen && (state == TRANSFER);
    assign srch_addr = {~post_scan, scan_addr[1:0]};  // slot 31-n holds match n

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            step_d <= '0;
        end else begin
            step_d <= {step_d[1:0], rd_step};
        end
    end

    assign clr_we = step_d[2];

    always_ff @(posedge clk) begin
        if (step_d[1]) begin
            buf_q <= bank_sel ? q_a : q_b;
        end
    end

    always_comb begin
        if (!bank_sel) begin
            addr_a = srch_addr;
            data_a = table_q;
            we_a   = srch_we;
            addr_b = rd_slot;
            data_b = CLR_VAL;
            we_b   = clr_we;
        end else begin
            addr_a = rd_slot;
            data_a = CLR_VAL;
            we_a   = clr_we;
            addr_b = srch_addr;
            data_b = table_q;
            we_b   = srch_we;
        end
    end

    obj_ram bank_a (
        .clk  (clk),
        .addr (addr_a),
        .data (data_a),
        .we   (we_a),
        .q    (q_a)
    );

    obj_ram bank_b (
        .clk  (clk),
        .addr (addr_b),
        .data (data_b),
        .we   (we_b),
        .q    (q_b)
    );

endmodule

`default_nettype wire

/* hdl/obj_table.sv */
`default_nettype none

// object attribute table, 96 entries of four bytes
// the cpu owns the write port, the scan logic owns the read port
module obj_table
    import obj_pkg::*;
(
    input  wire       clk,
    input  wire       cpu_we,
    input  tab_addr_t cpu_addr,
    input  obj_byte_t cpu_data,
    input  tab_addr_t scan_addr,
    output obj_byte_t table_q
);

    obj_byte_t mem [OBJ_COUNT*4];

    logic cpu_hit;

    // bytes above the table are dropped
    assign cpu_hit = cpu_we && (cpu_addr < tab_addr_t'(OBJ_COUNT*4));

    always_ff @(posedge clk) begin
        if (cpu_hit) begin
            mem[cpu_addr] <= cpu_data;
        end
    end

    // scan side, data one clock after the address
    always_ff @(posedge clk) begin
        table_q <= mem[scan_addr];
    end

endmodule

`default_nettype wire

/* hdl/obj_timing.sv */
`default_nettype none

module obj_timing
    import obj_pkg::*;
(
    input  wire   clk,
    input  wire   rst,
    output logic  draw_cen,
    output logic  hinit,
    output vpos_t v,
    output logic  lvbl
);

    logic [$clog2(CEN_DIV)-1:0] cen_cnt;
    logic [$clog2(H_TOTAL)-1:0] hcnt;    // draw step within the line
    logic [$clog2(V_TOTAL)-1:0] vcnt;    // line within the frame
    logic                       h_last;

    // clock enable divider
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cen_cnt  <= '0;
            draw_cen <= 1'b0;
        end else begin
            if (cen_cnt == ($bits(cen_cnt))'(CEN_DIV - 1)) begin
                cen_cnt <= '0;
            end else begin
                cen_cnt <= cen_cnt + 1'b1;
            end
            draw_cen <= (cen_cnt == ($bits(cen_cnt))'(CEN_DIV - 1));
        end
    end

    assign h_last = (hcnt == ($bits(hcnt))'(H_TOTAL - 1));

    // step and line counters move on draw_cen only
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (draw_cen) begin
            if (h_last) begin
                hcnt <= '0;
                if (vcnt == ($bits(vcnt))'(V_TOTAL - 1)) begin
                    vcnt <= '0;
                end else begin
                    vcnt <= vcnt + 1'b1;
                end
            end else begin
                hcnt <= hcnt + 1'b1;
            end
        end
    end

    // step 0 of each line, already counting the new line
    assign hinit = draw_cen && (hcnt == '0);

    // lines 256 to 261 alias onto 0 to 5 but are always blanked
    assign v = vcnt[7:0];

    assign lvbl = (vcnt >= ($bits(vcnt))'(V_VIS_START)) &&
                  (vcnt <= ($bits(vcnt))'(V_VIS_END));

endmodule

`default_nettype wire

/* hdl/obj_top.sv */
`default_nettype none

module obj_top
    import obj_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        cpu_we,
    input  tab_addr_t  cpu_addr,
    input  obj_byte_t  cpu_data,
    input  wire        flip,
    input  wire        rom_wait,
    output vpos_t      v,
    output logic       lvbl,
    output logic       hinit,
    output obj_entry_t obj_entry,
    output logic       obj_valid
);

    logic       draw_cen;
    tab_addr_t  scan_addr;
    obj_byte_t  table_q;
    slot_addr_t rd_slot;
    logic       rd_step;
    obj_byte_t  buf_q;

    obj_table u_table (
        .clk       (clk),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_data  (cpu_data),
        .scan_addr (scan_addr),
        .table_q   (table_q)
    );

    obj_timing u_timing (
        .clk      (clk),
        .rst      (rst),
        .draw_cen (draw_cen),
        .hinit    (hinit),
        .v        (v),
        .lvbl     (lvbl)
    );

    obj_scan_buf u_scan (
        .clk       (clk),
        .rst       (rst),
        .draw_cen  (draw_cen),
        .hinit     (hinit),
        .lvbl      (lvbl),
        .flip      (flip),
        .v         (v),
        .scan_addr (scan_addr),
        .table_q   (table_q),
        .rd_slot   (rd_slot),
        .rd_step   (rd_step),
        .buf_q     (buf_q)
    );

    obj_line_reader u_reader (
        .clk       (clk),
        .rst       (rst),
        .draw_cen  (draw_cen),
        .hinit     (hinit),
        .rom_wait  (rom_wait),
        .rd_slot   (rd_slot),
        .rd_step   (rd_step),
        .buf_q     (buf_q),
        .obj_entry (obj_entry),
        .obj_valid (obj_valid)
    );

endmodule

`default_nettype wire

/* verification/obj_tb.sv */
`default_nettype none

module obj_tb;
    import obj_pkg::*;

    localparam int LINE_CLKS  = H_TOTAL * CEN_DIV;
    localparam int FRAME_CLKS = V_TOTAL * LINE_CLKS;

    // one scenario row
    typedef struct packed {
        logic       flip;
        vpos_t      line;      // first search line watched
        logic [1:0] stall;     // 0 none, 1 alternating, 2 long bursts
        logic [3:0] count;     // lines to watch
    } scen_t;

    localparam int    N_SCEN = 8;
    localparam scen_t SCEN [N_SCEN] = '{
        '{1'b0, 8'd20,  2'd0, 4'd3},
        '{1'b0, 8'd98,  2'd0, 4'd4},   // more than 24 objects on these lines
        '{1'b1, 8'd120, 2'd0, 4'd3},
        '{1'b0, 8'd140, 2'd1, 4'd3},
        '{1'b1, 8'd160, 2'd2, 4'd3},
        '{1'b0, 8'd236, 2'd0, 4'd6},   // runs into vertical blank
        '{1'b0, 8'd98,  2'd1, 4'd4},   // next frame, crowded lines with stalls
        '{1'b1, 8'd200, 2'd2, 4'd3}
    };

    logic       clk = 1'b0;
    logic       rst;
    logic       cpu_we;
    tab_addr_t  cpu_addr;
    obj_byte_t  cpu_data;
    logic       flip;
    logic       rom_wait;
    vpos_t      v;
    logic       lvbl;
    logic       hinit;
    obj_entry_t obj_entry;
    logic       obj_valid;

    logic [1:0] stall_mode;
    logic [7:0] cyc;
    obj_byte_t  tab [OBJ_COUNT*4];          // copy of the attribute table
    obj_entry_t expected [OBJ_MAX_LINE];    // entries of one line, in read order
    int         hit_total;

    obj_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_data  (cpu_data),
        .flip      (flip),
        .rom_wait  (rom_wait),
        .v         (v),
        .lvbl      (lvbl),
        .hinit     (hinit),
        .obj_entry (obj_entry),
        .obj_valid (obj_valid)
    );

    always #5 clk = ~clk;

    // rom stall patterns, draw steps come every fourth clock
    always @(posedge clk) begin
        cyc <= cyc + 1'b1;
        case (stall_mode)
            2'd1:    rom_wait <= cyc[2];          // every other draw step
            2'd2:    rom_wait <= (cyc < 8'd96);   // 24 of 64 draw steps
            default: rom_wait <= 1'b0;
        endcase
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Y + ~vf + K with its four upper bits set
    function automatic logic covers_line(input obj_byte_t y, input vpos_t line, input logic flp);
        vpos_t     vf;
        obj_byte_t k;
        obj_byte_t sum;
        vf  = flp ? ~line : line;
        k   = flp ? 8'd2 : 8'd254;
        sum = y + ~vf + k;
        return &sum[7:4];
    endfunction

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_entry(input obj_entry_t got, input obj_entry_t exp, input int idx);
        if (got !== exp) begin
            $display("ERROR %0t obj_entry[%0d]: expected %h, got %h", $time, idx, exp, got);
            stop_run();
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got != exp) begin
            $display("ERROR %0t entry count: expected %0d, got %0d", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_vpos(input vpos_t got, input vpos_t exp);
        if (got !== exp) begin
            $display("ERROR %0t v: expected %0d, got %0d", $time, exp, got);
            stop_run();
        end
    endtask

    task automatic check_lvbl(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %0t lvbl: expected %b, got %b", $time, exp, got);
            stop_run();
        end
    endtask

    // a bound assertion failure ends the run at once
    always @(negedge clk) begin
        if (dut0.u_scan.u_scan_assert.fail_cnt + dut0.u_reader.u_rd_assert.fail_cnt != 0) begin
            $display("a bound assertion failed during the run");
            stop_run();
        end
    end

    task automatic load_table();
        logic [31:0] seed;
        seed = 32'h8f68_9d6d;
        for (int a = 0; a < OBJ_COUNT*4; a++) begin
            seed   = lcg_next(seed);
            tab[a] = seed[23:16];
        end
        // entries 40 to 69 all cover lines 98 to 101
        for (int i = 40; i < 70; i++) begin
            tab[4*i+2] = obj_byte_t'(95 + i % 4);
        end
        for (int a = 0; a < OBJ_COUNT*4; a++) begin
            @(posedge clk);
            cpu_we   <= 1'b1;
            cpu_addr <= tab_addr_t'(a);
            cpu_data <= tab[a];
        end
        @(posedge clk);
        cpu_we <= 1'b0;
    endtask

    task automatic wait_line_start(input vpos_t target);
        int   n;
        logic found;
        n     = 0;
        found = 1'b0;
        while (!found && n < 2*FRAME_CLKS) begin
            @(negedge clk);
            n++;
            found = hinit && (v == target);
        end
        if (!found) begin
            $display("timeout while waiting for line %0d to start", target);
            stop_run();
        end
    endtask

    // expected read-out of the bank filled while searching line s
    task automatic build_expected(input vpos_t s, input logic flp);
        obj_entry_t found [$];
        obj_entry_t e;
        int         n;
        if (s >= V_VIS_START && s <= V_VIS_END) begin
            for (int i = 0; i < OBJ_COUNT && found.size() < OBJ_MAX_LINE; i++) begin
                if (covers_line(tab[4*i+2], s, flp)) begin
                    e.b0 = tab[4*i];
                    e.b1 = tab[4*i+1];
                    e.b2 = tab[4*i+2];
                    e.b3 = tab[4*i+3];
                    found.push_back(e);
                end
            end
        end
        hit_total += found.size();
        // match n sits in slot 31-n, slots are read from 8 upwards
        for (int j = 0; j < OBJ_MAX_LINE; j++) begin
            n = 31 - (SLOT_FIRST + j);
            expected[j] = (n < found.size()) ? found[n] : {4{CLR_VAL}};
        end
    endtask

    // checks every strobe up to the next line start
    task automatic collect_line(input vpos_t next_line);
        int   n;
        int   idx;
        logic done;
        n    = 0;
        idx  = 0;
        done = 1'b0;
        while (!done && n < LINE_CLKS + 16) begin
            @(negedge clk);
            n++;
            if (obj_valid) begin
                if (idx < OBJ_MAX_LINE) begin
                    check_entry(obj_entry, expected[idx], idx);
                end
                idx++;
            end
            done = hinit;
        end
        if (!done) begin
            $display("timeout, the next line never started");
            stop_run();
        end
        check_count(idx, OBJ_MAX_LINE);
        // the line that has just started
        check_vpos(v, next_line);
        check_lvbl(lvbl, (next_line >= V_VIS_START) && (next_line <= V_VIS_END));
    endtask

    initial begin
        rst        = 1'b1;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_data   = '0;
        flip       = 1'b0;
        rom_wait   = 1'b0;
        stall_mode = 2'd0;
        cyc        = '0;
        hit_total  = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        load_table();   // done within line 0, long before the first visible search

        for (int r = 0; r < N_SCEN; r++) begin
            @(posedge clk);
            flip       <= SCEN[r].flip;
            stall_mode <= SCEN[r].stall;
            wait_line_start(SCEN[r].line);
            wait_line_start(SCEN[r].line + 8'd1);   // search of the first line is done
            for (int k = 0; k < SCEN[r].count; k++) begin
                build_expected(SCEN[r].line + k, SCEN[r].flip);
                collect_line(vpos_t'(SCEN[r].line + k + 2));
            end
        end

        if (hit_total == 0) begin
            $display("no watched line held a single matching object");
            stop_run();
        end
        if (dut0.u_scan.u_scan_assert.fail_cnt + dut0.u_reader.u_rd_assert.fail_cnt != 0) begin
            $display("a bound assertion failed during the run");
            stop_run();
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verification/obj_tb_assert.sv */
`default_nettype none

// checks on the scan buffer and the line reader, bound into both
module obj_tb_assert (
    input wire clk,
    input wire rst,
    input wire rom_wait,
    input wire rd_step,
    input wire obj_valid,
    input wire srch_we,
    input wire clr_we
);

    int fail_cnt = 0;   // polled by the testbench

    // a stalled rom holds the reader
    no_step_in_wait: assert property (@(posedge clk) disable iff (rst)
        !(rd_step && rom_wait))
        else begin
            $error("rd_step issued while rom_wait is high");
            fail_cnt++;
        end

    single_valid: assert property (@(posedge clk) disable iff (rst)
        obj_valid |=> !obj_valid)
        else begin
            $error("obj_valid high on two clocks in a row");
            fail_cnt++;
        end

    // search writes sit on draw_cen, clear writes three clocks after a step
    no_write_clash: assert property (@(posedge clk) disable iff (rst)
        !(srch_we && clr_we))
        else begin
            $error("search write and clear write in the same clock");
            fail_cnt++;
        end

endmodule

bind obj_scan_buf obj_tb_assert u_scan_assert (
    .clk       (clk),
    .rst       (rst),
    .rom_wait  (1'b0),
    .rd_step   (rd_step),
    .obj_valid (1'b0),
    .srch_we   (srch_we),
    .clr_we    (clr_we)
);

bind obj_line_reader obj_tb_assert u_rd_assert (
    .clk       (clk),
    .rst       (rst),
    .rom_wait  (rom_wait),
    .rd_step   (rd_step),
    .obj_valid (obj_valid),
    .srch_we   (1'b0),
    .clr_we    (1'b0)
);

`default_nettype wire
